/* source/rv32m_consts.svh */
/* Widths and latency for the RV32M multiply path.
   MUL_STAGES must match the register stages built into the multiplier. */

`ifndef RV32M_CONSTS_SVH
`define RV32M_CONSTS_SVH

// data word width of the integer core.
`define XLEN 32

// destination register address width for 32 architectural registers.
`define REG_ADDR_W 5

// cycles from an accepted start to the finished pulse.
`define MUL_STAGES 3

`endif

/* source/rv32m_pkg.sv */
/* Shared types for the RV32M multiply path.
   Division encodings are not represented here. */

package rv32m_pkg;

`include "rv32m_consts.svh"

  // signedness of the two operands with the first operand named first.
  typedef enum logic [1:0] {
    SIGNED          = 2'b00, // both operands signed.
    UNSIGNED        = 2'b01, // both operands unsigned.
    SIGNED_UNSIGNED = 2'b10, // first signed and second unsigned.
    UNSIGNED_SIGNED = 2'b11  // first unsigned and second signed.
  } sign_type_t;

  // multiply group of the M extension funct3 field.
  // codes with bit 2 set are the divide group and have no name here.
  typedef enum logic [2:0] {
    MUL    = 3'd0, // low word of signed x signed.
    MULH   = 3'd1, // high word of signed x signed.
    MULHSU = 3'd2, // high word of signed x unsigned.
    MULHU  = 3'd3  // high word of unsigned x unsigned.
  } mul_funct3_t;

  // the two result words of a full product with the upper word first.
  typedef struct packed {
    logic [`XLEN-1:0] hi;
    logic [`XLEN-1:0] lo;
  } product_words_t;

  // the full product is written as one value and read back as words.
  typedef union packed {
    logic [2*`XLEN-1:0] value;
    product_words_t     words;
  } product_t;

endpackage

/* source/mul_op_decoder.sv */
/* Purely combinational decode of the M extension funct3 field.
   Divide codes (bit 2 set) are refused and never start the multiplier. */

`timescale 1ns/1ps

module mul_op_decoder
  import rv32m_pkg::*;
(
  input  logic       start,        // one-cycle request from the execute stage.
  input  logic [2:0] funct3,       // raw funct3 of the instruction.
  output logic       start_mu,     // start strobe for the multiply unit.
  output sign_type_t is_signed,    // operand signedness.
  output logic       high_low_sel  // 1 selects the upper product word.
);

  mul_funct3_t op;
  logic        is_div;

  // the enum only names the multiply codes, so the cast keeps all 3 bits.
  assign op = mul_funct3_t'(funct3);

  // bit 2 marks the divide group, which belongs to a separate unit.
  assign is_div = funct3[2];

  // a divide code must not reach the multiplier at all.
  assign start_mu = start & ~is_div;

  always_comb begin
    // safe values for codes the multiplier does not serve.
    is_signed    = SIGNED;
    high_low_sel = 1'b0;
    case (op)
      MUL: begin
        is_signed    = SIGNED;          // low word is the same for any signedness.
        high_low_sel = 1'b0;
      end
      MULH: begin
        is_signed    = SIGNED;
        high_low_sel = 1'b1;
      end
      MULHSU: begin
        is_signed    = SIGNED_UNSIGNED; // rs1 is signed and rs2 unsigned.
        high_low_sel = 1'b1;
      end
      MULHU: begin
        is_signed    = UNSIGNED;
        high_low_sel = 1'b1;
      end
      default: begin
        // divide group. start_mu is already masked above.
        is_signed    = SIGNED;
        high_low_sel = 1'b0;
      end
    endcase
  end

endmodule

/* source/multiplier.sv */
/* Three-stage pipelined 32x32 multiplier with a full 64-bit product.
   A new operation may start every cycle. The first operand is the multiplier port. */

`timescale 1ns/1ps

`include "rv32m_consts.svh"

module multiplier
  import rv32m_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  logic [`XLEN-1:0] multiplicand,  // second operand.
  input  logic [`XLEN-1:0] multiplier,    // first operand.
  input  sign_type_t       is_signed,
  input  logic             start,
  output logic             finished,      // product is valid this cycle.
  output logic             next_finished, // product is valid next cycle.
  output product_t         product
);

  localparam int HALF = `XLEN / 2;

  logic               mplier_signed, mcand_signed;
  logic               mplier_neg, mcand_neg;
  logic [`XLEN-1:0]   mplier_mag, mcand_mag;
  logic [2:0]         valid;           // one bit per stage.

  // stage 1 registers.
  logic [`XLEN-1:0]   mag_a_q, mag_b_q;
  logic               neg_s1_q;

  // stage 2 registers.
  logic [`XLEN-1:0]   pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q;
  logic               neg_s2_q;

  logic [2*`XLEN-1:0] mid_lh, mid_hl;
  logic [2*`XLEN-1:0] sum;

  // the first operand is signed for SIGNED and SIGNED_UNSIGNED.
  assign mplier_signed = (is_signed == SIGNED) || (is_signed == SIGNED_UNSIGNED);
  // the second operand is signed for SIGNED and UNSIGNED_SIGNED.
  assign mcand_signed  = (is_signed == SIGNED) || (is_signed == UNSIGNED_SIGNED);

  assign mplier_neg = mplier_signed & multiplier[`XLEN-1];
  assign mcand_neg  = mcand_signed & multiplicand[`XLEN-1];

  // the magnitude of the most negative value is 2**31, which still fits unsigned.
  assign mplier_mag = mplier_neg ? -multiplier : multiplier;
  assign mcand_mag  = mcand_neg ? -multiplicand : multiplicand;

  // the valid bits mark which stages hold an operation.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else begin
      valid <= {valid[1:0], start}; // one step per stage.
    end
  end

  assign next_finished = valid[1];
  assign finished      = valid[2];

  // stage 1 holds unsigned magnitudes and the sign of the result.
  always_ff @(posedge CLK) begin
    if (start) begin
      mag_a_q  <= mplier_mag;
      mag_b_q  <= mcand_mag;
      neg_s1_q <= mplier_neg ^ mcand_neg;
    end
  end

  // stage 2 forms four 16x16 partial products.
  always_ff @(posedge CLK) begin
    if (valid[0]) begin
      pp_ll_q  <= mag_a_q[HALF-1:0] * mag_b_q[HALF-1:0];
      pp_lh_q  <= mag_a_q[HALF-1:0] * mag_b_q[`XLEN-1:HALF];
      pp_hl_q  <= mag_a_q[`XLEN-1:HALF] * mag_b_q[HALF-1:0];
      pp_hh_q  <= mag_a_q[`XLEN-1:HALF] * mag_b_q[`XLEN-1:HALF];
      neg_s2_q <= neg_s1_q;
    end
  end

  // the cross terms sit HALF bits up in the 64-bit sum.
  assign mid_lh = {{HALF{1'b0}}, pp_lh_q, {HALF{1'b0}}};
  assign mid_hl = {{HALF{1'b0}}, pp_hl_q, {HALF{1'b0}}};

  // the outer terms do not overlap, so they concatenate without an adder.
  assign sum = {pp_hh_q, pp_ll_q} + mid_lh + mid_hl; // cannot overflow 64 bits.

  // stage 3 adds up and restores the sign in two's complement.
  always_ff @(posedge CLK) begin
    if (valid[1]) begin
      product.value <= neg_s2_q ? -sum : sum;
    end
  end

endmodule

/* source/multiply_unit.sv */
/* Multiply wrapper for the execute stage. There is no back-pressure, so the consumer
   takes wdata_mu and reg_rd_mu in the cycle that done_mu is high. */

`timescale 1ns/1ps

`include "rv32m_consts.svh"

module multiply_unit
  import rv32m_pkg::*;
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start_mu,
  input  sign_type_t            is_signed,
  input  logic                  high_low_sel, // 1 returns the upper word.
  input  logic [`XLEN-1:0]      rs1_data,
  input  logic [`XLEN-1:0]      rs2_data,
  input  logic [`REG_ADDR_W-1:0] reg_rd,
  output logic                  done_mu,
  output logic                  busy_mu,
  output logic [`XLEN-1:0]      wdata_mu,
  output logic [`REG_ADDR_W-1:0] reg_rd_mu
);

  localparam int LAST = `MUL_STAGES - 1;

  logic [`XLEN-1:0]                   op_first, op_second;
  sign_type_t                         mode;
  logic                               next_done;
  product_t                           product;
  logic [`MUL_STAGES-1:0]             sel_pipe; // high/low select per stage.
  logic [`MUL_STAGES-1:0][`REG_ADDR_W-1:0] rd_pipe; // destination per stage.

  // SIGNED_UNSIGNED is turned into UNSIGNED_SIGNED by swapping the operands.
  // the multiplier then never sees a signed first operand with an unsigned second.
  assign op_first  = (is_signed == SIGNED_UNSIGNED) ? rs2_data : rs1_data;
  assign op_second = (is_signed == SIGNED_UNSIGNED) ? rs1_data : rs2_data;
  assign mode      = (is_signed == SIGNED_UNSIGNED) ? UNSIGNED_SIGNED : is_signed;

  multiplier u_multiplier (
    .CLK           (CLK),
    .nRST          (nRST),
    .multiplicand  (op_second),
    .multiplier    (op_first),
    .is_signed     (mode),
    .start         (start_mu),
    .finished      (done_mu),
    .next_finished (next_done),
    .product       (product)
  );

  // select and rd follow each operation down the pipeline.
  // the last stage only loads when a result arrives, so rd_out holds between results.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      sel_pipe <= '0;
      rd_pipe  <= '0;
    end else begin
      sel_pipe[0] <= high_low_sel;
      rd_pipe[0]  <= reg_rd;
      for (int i = 1; i < LAST; i++) begin
        sel_pipe[i] <= sel_pipe[i-1];
        rd_pipe[i]  <= rd_pipe[i-1];
      end
      if (next_done) begin
        sel_pipe[LAST] <= sel_pipe[LAST-1]; // lines up with done_mu.
        rd_pipe[LAST]  <= rd_pipe[LAST-1];
      end
    end
  end

  assign wdata_mu  = sel_pipe[LAST] ? product.words.hi : product.words.lo;
  assign reg_rd_mu = rd_pipe[LAST];

  // busy is only raised in the cycle of a new request.
  assign busy_mu = start_mu & ~done_mu;

endmodule

/* source/mul_exec_top.sv */
/* Multiply path of the RV32M execute stage built from the decoder and the multiply unit.
   Results come out exactly MUL_STAGES cycles after start, in issue order. */

`timescale 1ns/1ps

`include "rv32m_consts.svh"

module mul_exec_top
  import rv32m_pkg::*;
(
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   start,    // at most one instruction per cycle.
  input  logic [2:0]             funct3,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  input  logic [`REG_ADDR_W-1:0] rd,
  output logic                   done,
  output logic                   busy,
  output logic [`XLEN-1:0]       wdata,
  output logic [`REG_ADDR_W-1:0] rd_out
);

  logic       start_mu;
  sign_type_t is_signed;
  logic       high_low_sel;

  mul_op_decoder u_decoder (
    .start        (start),
    .funct3       (funct3),
    .start_mu     (start_mu),
    .is_signed    (is_signed),
    .high_low_sel (high_low_sel)
  );

  multiply_unit u_multiply_unit (
    .CLK          (CLK),
    .nRST         (nRST),
    .start_mu     (start_mu),
    .is_signed    (is_signed),
    .high_low_sel (high_low_sel),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .reg_rd       (rd),
    .done_mu      (done),
    .busy_mu      (busy),
    .wdata_mu     (wdata),
    .reg_rd_mu    (rd_out)
  );

endmodule

/* tests/mul_exec_checker.sv */
/* Protocol assertions for the multiply path that are bound into mul_exec_top.
   Inputs are assumed stable at the rising edge, which holds for the testbench. */

`timescale 1ns/1ps

`include "rv32m_consts.svh"

module mul_exec_checker (
  input logic       CLK,
  input logic       nRST,
  input logic       start,
  input logic [2:0] funct3,
  input logic       done,
  input logic       busy
);

  logic mul_start; // a start the multiplier accepts.
  logic div_start; // a start with a divide code, which the decoder refuses.

  assign mul_start = start & ~funct3[2];
  assign div_start = start & funct3[2];

  // the finished valid bits are cleared asynchronously.
  done_low_in_reset: assert property (@(posedge CLK) !nRST |-> !done)
    else $error("done is high while reset is asserted");

  // every accepted start comes out MUL_STAGES edges later.
  mul_latency: assert property (@(posedge CLK) disable iff (!nRST)
    $past(mul_start, `MUL_STAGES) |-> done)
    else $error("multiply start did not produce done after the pipeline latency");

  // there is only one start per cycle, so a divide start owns its result slot.
  div_no_done: assert property (@(posedge CLK) disable iff (!nRST)
    $past(div_start, `MUL_STAGES) |-> !done)
    else $error("divide code start produced a done");

  // busy only marks the cycle of an accepted request.
  busy_rule: assert property (@(posedge CLK) busy == (mul_start && !done))
    else $error("busy does not equal an accepted start without done");

endmodule

bind mul_exec_top mul_exec_checker i_mul_exec_checker (
  .CLK    (CLK),
  .nRST   (nRST),
  .start  (start),
  .funct3 (funct3),
  .done   (done),
  .busy   (busy)
);

/* tests/mul_exec_tb.sv */
/* Directed and random test of the RV32M multiply path against a model.
   Stimulus comes from a 16-bit Galois LFSR with a fixed seed, so runs repeat. */

`timescale 1ns/1ps

`include "rv32m_consts.svh"

module mul_exec_tb
  import rv32m_pkg::*;
();

  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 12;  // calls made by directed_ops.
  localparam int RANDOM_CYCLES   = 600;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                   + `MUL_STAGES + 40;

  logic                   CLK;
  logic                   nRST;
  logic                   start;
  logic [2:0]             funct3;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`REG_ADDR_W-1:0] rd;
  logic                   done;
  logic                   busy;
  logic [`XLEN-1:0]       wdata;
  logic [`REG_ADDR_W-1:0] rd_out;

  logic [15:0]            lfsr_state;
  logic [`MUL_STAGES-1:0] issue_hist;     // accepted starts with the newest in bit 0.
  logic [`XLEN-1:0]       exp_wdata_q[$]; // expected results in issue order.
  logic [`REG_ADDR_W-1:0] exp_rd_q[$];
  int                     value_errors;
  int                     protocol_errors;
  int                     cycle_count;
  int                     mul_count;      // accepted multiplies of the random phase.

  mul_exec_top i_mul_exec_top (
    .CLK      (CLK),
    .nRST     (nRST),
    .start    (start),
    .funct3   (funct3),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (rd),
    .done     (done),
    .busy     (busy),
    .wdata    (wdata),
    .rd_out   (rd_out)
  );

  always #10 CLK = ~CLK; // 20 ns period.

  // taps 16, 14, 13 and 11 give a maximal length sequence.
  function automatic logic [15:0] step_lfsr(input logic [15:0] state);
    step_lfsr = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // one LFSR step is taken for every bit and the first bit ends up most significant.
  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = step_lfsr(lfsr_state);
    end
    return value;
  endfunction

  // operand values at the edges of the signed and unsigned ranges.
  function automatic logic [`XLEN-1:0] corner_value(input logic [2:0] sel);
    case (sel)
      3'd0:    corner_value = 32'h0000_0000;
      3'd1:    corner_value = 32'hFFFF_FFFF;
      3'd2:    corner_value = 32'h8000_0000; // most negative.
      3'd3:    corner_value = 32'h7FFF_FFFF;
      3'd4:    corner_value = 32'h0000_0001;
      3'd5:    corner_value = 32'hFFFF_FFFE;
      3'd6:    corner_value = 32'h8000_0001;
      default: corner_value = 32'h0000_FFFF;
    endcase
  endfunction

  // extends both operands to 66 bits by the RISC-V rules and keeps one word.
  function automatic logic [`XLEN-1:0] expected_word(input logic [2:0] f3,
                                                     input logic [`XLEN-1:0] a,
                                                     input logic [`XLEN-1:0] b);
    logic signed [65:0] ext_a;
    logic signed [65:0] ext_b;
    logic signed [65:0] full;
    // rs1 is signed except for MULHU.
    ext_a = (f3 == MULHU) ? {34'b0, a} : {{34{a[31]}}, a};
    // rs2 is signed only for MUL and MULH.
    ext_b = (f3 == MUL || f3 == MULH) ? {{34{b[31]}}, b} : {34'b0, b};
    full  = ext_a * ext_b;
    expected_word = (f3 == MUL) ? full[31:0] : full[63:32];
  endfunction

  // outputs are registered, so they are stable at the falling edge.
  task automatic check_outputs();
    logic [`XLEN-1:0]       exp_wdata;
    logic [`REG_ADDR_W-1:0] exp_rd;
    if (done !== issue_hist[`MUL_STAGES-1]) begin
      $display("FAILED done: got %h expected %h", done, issue_hist[`MUL_STAGES-1]);
      protocol_errors++;
    end
    if (done === 1'b1) begin
      if (exp_wdata_q.size() == 0) begin
        $display("done was raised with no multiply outstanding");
        protocol_errors++;
      end else begin
        exp_wdata = exp_wdata_q.pop_front();
        exp_rd    = exp_rd_q.pop_front();
        if (wdata !== exp_wdata) begin
          $display("FAILED wdata: got %h expected %h", wdata, exp_wdata);
          value_errors++;
        end
        if (rd_out !== exp_rd) begin
          $display("FAILED rd_out: got %h expected %h", rd_out, exp_rd);
          value_errors++;
        end
      end
    end
  endtask

  // one clock cycle checks what came out and then drives the next request.
  task automatic run_cycle(input logic                   go,
                           input logic [2:0]             f3,
                           input logic [`XLEN-1:0]       a,
                           input logic [`XLEN-1:0]       b,
                           input logic [`REG_ADDR_W-1:0] r);
    logic is_mul;
    is_mul = go & ~f3[2]; // divide codes never reach the multiplier.
    @(negedge CLK);
    check_outputs();
    start    = go;
    funct3   = f3;
    rs1_data = a;
    rs2_data = b;
    rd       = r;
    if (is_mul) begin
      exp_wdata_q.push_back(expected_word(f3, a, b));
      exp_rd_q.push_back(r);
    end
    issue_hist = {issue_hist[`MUL_STAGES-2:0], is_mul};
    #1;
    // busy is combinational from the new inputs and the held done.
    if (busy !== (is_mul & ~done)) begin
      $display("FAILED busy: got %h expected %h", busy, is_mul & ~done);
      protocol_errors++;
    end
  endtask

  // back-to-back corner cases with divide codes mixed into the stream.
  task automatic directed_ops();
    run_cycle(1'b1, MUL,    32'd7,        32'd6,        5'd1);
    run_cycle(1'b1, MULH,   32'h8000_0000, 32'h8000_0000, 5'd2);
    run_cycle(1'b1, MULHSU, 32'hFFFF_FFFE, 32'hFFFF_FFFF, 5'd3);
    run_cycle(1'b1, MULHSU, 32'h8000_0000, 32'hFFFF_FFFF, 5'd4);
    run_cycle(1'b1, MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd5);
    run_cycle(1'b1, 3'd4,   32'h0000_0064, 32'h0000_0005, 5'd6);  // DIV.
    run_cycle(1'b1, MUL,    32'h0000_0000, 32'hFFFF_FFFF, 5'd7);
    run_cycle(1'b1, 3'd6,   32'h1234_5678, 32'h0000_0010, 5'd8);  // REM.
    run_cycle(1'b1, MULH,   32'hFFFF_FFFF, 32'h0000_0001, 5'd9);
    run_cycle(1'b1, MULHSU, 32'h1234_5678, 32'h9ABC_DEF0, 5'd10);
    run_cycle(1'b1, MUL,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd11);
    run_cycle(1'b0, MUL,    '0,            '0,            '0);
  endtask

  task automatic random_cycle();
    logic                   go;
    logic                   div;
    logic [2:0]             f3;
    logic [`XLEN-1:0]       a;
    logic [`XLEN-1:0]       b;
    logic [`REG_ADDR_W-1:0] r;
    go  = (rand_bits(2) != 0);                   // three starts in four cycles.
    div = (rand_bits(3) == 0);                   // one in eight is a divide code.
    f3  = {div, 2'(rand_bits(2))};
    a   = rand_bits(`XLEN);
    b   = rand_bits(`XLEN);
    r   = `REG_ADDR_W'(rand_bits(`REG_ADDR_W));
    if (go && !div) begin
      mul_count++;
      if (mul_count % 16 == 0) begin             // every sixteenth multiply uses corners.
        a = corner_value(3'(rand_bits(3)));
        b = corner_value(3'(rand_bits(3)));
      end
    end
    run_cycle(go, f3, a, b, r);
  endtask

  // the run ends here if the test sequence stops making progress.
  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    CLK             = 1'b0;
    nRST            = 1'b1;
    start           = 1'b0;
    funct3          = 3'd0;
    rs1_data        = '0;
    rs2_data        = '0;
    rd              = '0;
    lfsr_state      = 16'd21419;
    issue_hist      = '0;
    value_errors    = 0;
    protocol_errors = 0;
    cycle_count     = 0;
    mul_count       = 0;
    #5 nRST = 1'b0; // a clean falling edge for the asynchronous reset.
    repeat (RESET_CYCLES) begin
      @(posedge CLK);
      if (done !== 1'b0) begin
        $display("FAILED done: got %h expected %h during reset", done, 1'b0);
        protocol_errors++;
      end
      if (rd_out !== '0) begin
        $display("FAILED rd_out: got %h expected %h during reset", rd_out, 5'd0);
        protocol_errors++;
      end
    end
    @(negedge CLK);
    nRST = 1'b1;
    directed_ops();
    repeat (RANDOM_CYCLES) random_cycle();
    repeat (`MUL_STAGES + 2) run_cycle(1'b0, 3'd0, '0, '0, '0); // drain the pipeline.
    if (exp_wdata_q.size() != 0) begin
      $display("%0d multiply results never came out", exp_wdata_q.size());
      protocol_errors++;
    end
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+source
source/rv32m_pkg.sv
source/mul_op_decoder.sv
source/multiplier.sv
source/multiply_unit.sv
source/mul_exec_top.sv
tests/mul_exec_checker.sv
tests/mul_exec_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the multiply path testbench with Verilator and runs it once.
# The exit status is 0 only when the testbench prints its pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
  -f vlog.f --top-module mul_exec_tb -Mdir obj_dir -o mul_exec_sim

# an assertion failure stops the simulator with a nonzero status, so keep going.
sim_output=$(./obj_dir/mul_exec_sim 2>&1) || true
echo "$sim_output"

if grep -qx "Simulation PASSED" <<< "$sim_output"; then
  exit 0
else
  exit 1
fi
